// ==== Bender.yml ====
package:
  name: ahb_input_stage

sources:
  - include_dirs:
      - design
    files:
      - design/ahb_input_pkg.sv
      - design/wrap_boundary.sv
      - design/burst_fixup.sv
      - design/input_hold.sv
      - design/ahb_input_stage.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/ahb_input_props.sv
      - sim/tb_ahb_input_stage.sv

// ==== all.f ====
+incdir+design
design/ahb_input_pkg.sv
design/wrap_boundary.sv
design/burst_fixup.sv
design/input_hold.sv
design/ahb_input_stage.sv
sim/ahb_input_props.sv
sim/tb_ahb_input_stage.sv

// ==== design/ahb_input_macros.svh ====
/*
  AHB field widths plus HTRANS, HBURST and HRESP encodings
*/
`ifndef AHB_INPUT_MACROS_SVH
`define AHB_INPUT_MACROS_SVH

// Bus field widths
`define AHB_ADDR_W   32
`define AHB_TRANS_W  2
`define AHB_SIZE_W   3
`define AHB_BURST_W  3
`define AHB_PROT_W   4
`define AHB_RESP_W   2

// HTRANS
`define TRN_IDLE     2'b00   // No transfer
`define TRN_BUSY     2'b01   // Manager inserting a wait beat
`define TRN_NONSEQ   2'b10   // First beat or single
`define TRN_SEQ      2'b11   // Follow-on burst beat

// HBURST
`define BUR_SINGLE   3'b000
`define BUR_INCR     3'b001  // Undefined length
`define BUR_WRAP4    3'b010
`define BUR_INCR4    3'b011
`define BUR_WRAP8    3'b100
`define BUR_INCR8    3'b101
`define BUR_WRAP16   3'b110
`define BUR_INCR16   3'b111

// HRESP, only the two used here
`define RSP_OKAY     2'b00
`define RSP_ERROR    2'b01

`endif

// ==== design/ahb_input_pkg.sv ====
/*
  Vector typedefs for AHB fields and the packed address-phase struct
*/
`include "ahb_input_macros.svh"

package ahb_input_pkg;

  // ----------------------------------------------------------------------
  // Field types
  // ----------------------------------------------------------------------
  typedef logic [`AHB_ADDR_W-1:0]  haddr_t;   // HADDR
  typedef logic [`AHB_TRANS_W-1:0] htrans_t;  // HTRANS
  typedef logic [`AHB_SIZE_W-1:0]  hsize_t;   // HSIZE
  typedef logic [`AHB_BURST_W-1:0] hburst_t;  // HBURST
  typedef logic [`AHB_PROT_W-1:0]  hprot_t;   // HPROT
  typedef logic [`AHB_RESP_W-1:0]  hresp_t;   // HRESP

  // Beat index inside a wrap window, up to 16 beats
  typedef logic [3:0] wrap_offset_t;

  // ----------------------------------------------------------------------
  // One address phase, 46 bits
  // ----------------------------------------------------------------------
  // Field order follows the manager port list
  typedef struct packed {
    logic    sel;    // Port select
    haddr_t  addr;   // Transfer address
    htrans_t trans;  // Transfer type
    logic    write;  // 1 for write
    hsize_t  size;   // Bytes per beat, log2
    hburst_t burst;  // Burst kind
    hprot_t  prot;   // Protection bits
  } ahb_addr_phase_t;

endpackage

// ==== design/ahb_input_stage.sv ====
/*
  AHB matrix input stage top: hold stage plus burst fixup
*/
`timescale 1ns/10ps

module ahb_input_stage (
  input  logic                           HCLK,
  input  logic                           HRESETn,
  // Manager address phase
  input  logic                           HSELS,
  input  ahb_input_pkg::haddr_t          HADDRS,
  input  ahb_input_pkg::htrans_t         HTRANSS,
  input  logic                           HWRITES,
  input  ahb_input_pkg::hsize_t          HSIZES,
  input  ahb_input_pkg::hburst_t         HBURSTS,
  input  ahb_input_pkg::hprot_t          HPROTS,
  input  logic                           HREADYS,
  // Output stage status
  input  logic                           active_ip,
  input  logic                           readyout_ip,
  input  ahb_input_pkg::hresp_t          resp_ip,
  // Manager response
  output logic                           HREADYOUTS,
  output ahb_input_pkg::hresp_t          HRESPS,
  // Toward output stage
  output ahb_input_pkg::ahb_addr_phase_t ip_phase,
  output logic                           held_tran_ip
);

  ahb_input_pkg::ahb_addr_phase_t in_phase;   // Packed manager inputs
  ahb_input_pkg::ahb_addr_phase_t mux_phase;  // Register or live phase
  ahb_input_pkg::htrans_t         sel_trans;
  logic                           load_reg;

  // ----------------------------------------------------------------------
  // Input packing
  // ----------------------------------------------------------------------
  assign in_phase.sel   = HSELS;
  assign in_phase.addr  = HADDRS;
  assign in_phase.trans = HTRANSS;
  assign in_phase.write = HWRITES;
  assign in_phase.size  = HSIZES;
  assign in_phase.burst = HBURSTS;
  assign in_phase.prot  = HPROTS;

  input_hold u_input_hold (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .in_phase     (in_phase),
    .HREADYS      (HREADYS),
    .active_ip    (active_ip),
    .readyout_ip  (readyout_ip),
    .resp_ip      (resp_ip),
    .mux_phase    (mux_phase),
    .sel_trans    (sel_trans),
    .load_reg     (load_reg),
    .HREADYOUTS   (HREADYOUTS),
    .HRESPS       (HRESPS),
    .held_tran_ip (held_tran_ip)
  );

  // Burst repair sits after the mux
  burst_fixup u_burst_fixup (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .in_phase  (in_phase),
    .mux_phase (mux_phase),
    .sel_trans (sel_trans),
    .load_reg  (load_reg),
    .HREADYS   (HREADYS),
    .active_ip (active_ip),
    .ip_phase  (ip_phase)
  );

endmodule

// ==== design/burst_fixup.sv ====
/*
  Early burst termination: burst override register and
  HTRANS/HBURST correction of the outgoing phase
*/
`timescale 1ns/10ps
`include "ahb_input_macros.svh"

module burst_fixup (
  input  logic                           HCLK,
  input  logic                           HRESETn,
  input  ahb_input_pkg::ahb_addr_phase_t in_phase,   // Live manager phase
  input  ahb_input_pkg::ahb_addr_phase_t mux_phase,  // From hold stage
  input  ahb_input_pkg::htrans_t         sel_trans,  // Raw HTRANS of mux_phase
  input  logic                           load_reg,
  input  logic                           HREADYS,
  input  logic                           active_ip,
  output ahb_input_pkg::ahb_addr_phase_t ip_phase    // To output stage
);

  logic burst_override;       // Burst was cut, finish as INCR
  logic burst_override_next;
  logic bound;                // Window boundary just crossed

  // ----------------------------------------------------------------------
  // Override tracking
  // ----------------------------------------------------------------------
  // A SEQ beat captured while another port owns the output
  // means the downstream burst was broken
  always_comb
  begin
    if (in_phase.trans == `TRN_NONSEQ || in_phase.trans == `TRN_IDLE)
      burst_override_next = 1'b0;      // New burst or end of burst
    else if (in_phase.trans == `TRN_SEQ && load_reg && !active_ip)
      burst_override_next = 1'b1;
    else
      burst_override_next = burst_override;
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      burst_override <= 1'b0;
    else if (HREADYS)
      burst_override <= burst_override_next;
  end

  wrap_boundary u_wrap_boundary (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .addr    (in_phase.addr),
    .size    (in_phase.size),
    .burst   (in_phase.burst),
    .trans   (in_phase.trans),
    .HREADYS (HREADYS),
    .bound   (bound)
  );

  // ----------------------------------------------------------------------
  // Outgoing phase correction
  // ----------------------------------------------------------------------
  always_comb
  begin
    ip_phase = mux_phase;
    if (burst_override && sel_trans != `TRN_NONSEQ)
      ip_phase.burst = `BUR_INCR;                    // Unknown remaining length
    if (burst_override && bound)
      ip_phase.trans = {mux_phase.trans[1], 1'b0};   // SEQ->NONSEQ, BUSY->IDLE
  end

endmodule

// ==== design/input_hold.sv ====
/*
  Holding register, pending flag and pass-through mux
  Response generation toward the manager
*/
`timescale 1ns/10ps
`include "ahb_input_macros.svh"

module input_hold (
  input  logic                           HCLK,
  input  logic                           HRESETn,
  input  ahb_input_pkg::ahb_addr_phase_t in_phase,     // Live manager address phase
  input  logic                           HREADYS,      // Bus-wide ready
  input  logic                           active_ip,    // Output stage serving this port
  input  logic                           readyout_ip,  // Ready from output stage
  input  ahb_input_pkg::hresp_t          resp_ip,      // Response from output stage
  output ahb_input_pkg::ahb_addr_phase_t mux_phase,    // Selected phase
  output ahb_input_pkg::htrans_t         sel_trans,    // Unmodified HTRANS of selected phase
  output logic                           load_reg,     // Capture strobe
  output logic                           HREADYOUTS,
  output ahb_input_pkg::hresp_t          HRESPS,
  output logic                           held_tran_ip  // Request to output stage
);

  ahb_input_pkg::ahb_addr_phase_t reg_phase;  // Captured address phase
  logic addr_valid;  // Active transfer to this port
  logic data_valid;  // Data phase of an active transfer
  logic pend_next;
  logic pend_reg;    // Held transfer waiting for output stage

  // ----------------------------------------------------------------------
  // Capture
  // ----------------------------------------------------------------------
  assign addr_valid = in_phase.sel & in_phase.trans[1];  // NONSEQ or SEQ only
  assign load_reg   = addr_valid & HREADYS;

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      reg_phase <= '0;
    else if (load_reg)
      reg_phase <= in_phase;  // Every accepted beat, replayed only if pending
  end

  // Data phase follows an accepted address phase
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_valid <= 1'b0;
    else if (HREADYS)
      data_valid <= addr_valid;
  end

  // ----------------------------------------------------------------------
  // Pending flag
  // ----------------------------------------------------------------------
  // Set when the output stage cannot take the beat now.
  // Cleared once the replay is driven and accepted downstream.
  always_comb
  begin
    if (load_reg && !active_ip)
      pend_next = 1'b1;
    else if (active_ip && readyout_ip)
      pend_next = 1'b0;
    else
      pend_next = pend_reg;
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      pend_reg <= 1'b0;
    else
      pend_reg <= pend_next;
  end

  assign held_tran_ip = load_reg | pend_reg;  // Live beat or held beat

  // ----------------------------------------------------------------------
  // Pass-through mux
  // ----------------------------------------------------------------------
  always_comb
  begin
    if (pend_reg)
    begin
      mux_phase       = reg_phase;
      mux_phase.sel   = 1'b1;         // Held beat always selects
      mux_phase.trans = `TRN_NONSEQ;  // Replay starts fresh downstream
    end
    else
    begin
      mux_phase = in_phase;           // Straight through
    end
  end

  // Burst logic needs the original type, not the forced NONSEQ
  assign sel_trans = pend_reg ? reg_phase.trans : in_phase.trans;

  // ----------------------------------------------------------------------
  // Response
  // ----------------------------------------------------------------------
  always_comb
  begin
    if (!data_valid)
    begin
      HREADYOUTS = 1'b1;         // Idle, busy or not selected
      HRESPS     = `RSP_OKAY;
    end
    else if (pend_reg)
    begin
      HREADYOUTS = 1'b0;         // Stall until replay completes
      HRESPS     = `RSP_OKAY;
    end
    else
    begin
      HREADYOUTS = readyout_ip;  // Forward output stage response
      HRESPS     = resp_ip;
    end
  end

endmodule

// ==== design/wrap_boundary.sv ====
/*
  Wrap-window boundary detection with registered flag
*/
`timescale 1ns/10ps
`include "ahb_input_macros.svh"

module wrap_boundary (
  input  logic                    HCLK,
  input  logic                    HRESETn,
  input  ahb_input_pkg::haddr_t   addr,
  input  ahb_input_pkg::hsize_t   size,
  input  ahb_input_pkg::hburst_t  burst,
  input  ahb_input_pkg::htrans_t  trans,
  input  logic                    HREADYS,
  output logic                    bound    // Last beat of window accepted
);

  ahb_input_pkg::wrap_offset_t offset_addr;  // Beat index from address
  ahb_input_pkg::wrap_offset_t check_addr;   // Masked to window length
  logic bound_next;
  logic bound_en;

  // Beat index, address scaled by transfer size
  always_comb
  begin
    case (size)
      3'b000:  offset_addr = addr[3:0];  // Byte
      3'b001:  offset_addr = addr[4:1];  // Halfword
      3'b010:  offset_addr = addr[5:2];  // Word
      3'b011:  offset_addr = addr[6:3];  // Doubleword
      default: offset_addr = addr[3:0];  // Wider sizes not handled
    endcase
  end

  // Keep only the bits inside the window, pad the rest with ones
  always_comb
  begin
    case (burst)
      `BUR_WRAP4:  check_addr = {2'b11, offset_addr[1:0]};
      `BUR_WRAP8:  check_addr = {1'b1, offset_addr[2:0]};
      `BUR_WRAP16: check_addr = offset_addr;
      default:     check_addr = 4'b0000;  // SINGLE and INCRx never wrap
    endcase
  end

  assign bound_next = &check_addr;
  assign bound_en   = trans[1] & HREADYS;  // Accepted active beat

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      bound <= 1'b0;
    else if (bound_en)
      bound <= bound_next;
  end

endmodule

// ==== sim/ahb_input_props.sv ====
/*
  Bound checks for the AHB input stage
  Tracks pending, override and boundary state from the bus signals
*/
`timescale 1ns/10ps
`include "ahb_input_macros.svh"

module ahb_input_props (
  input logic                           HCLK,
  input logic                           HRESETn,
  input logic                           HSELS,
  input ahb_input_pkg::haddr_t          HADDRS,
  input ahb_input_pkg::htrans_t         HTRANSS,
  input logic                           HWRITES,
  input ahb_input_pkg::hsize_t          HSIZES,
  input ahb_input_pkg::hburst_t         HBURSTS,
  input ahb_input_pkg::hprot_t          HPROTS,
  input logic                           HREADYS,
  input logic                           active_ip,
  input logic                           readyout_ip,
  input ahb_input_pkg::hresp_t          resp_ip,
  input logic                           HREADYOUTS,
  input ahb_input_pkg::hresp_t          HRESPS,
  input ahb_input_pkg::ahb_addr_phase_t ip_phase,
  input logic                           held_tran_ip
);

  int fail_count = 0;  // Failed assertions
  int n_pass;          // Live beats passed straight through
  int n_hold;          // Cycles with a held beat
  int n_stall;         // Held beat waiting on readyout_ip
  int n_ovr;           // SEQ beats leaving under override
  int n_wrap_seq;      // SEQ turned into NONSEQ
  int n_wrap_busy;     // BUSY turned into IDLE

  ahb_input_pkg::ahb_addr_phase_t live;       // Manager inputs as one phase
  ahb_input_pkg::ahb_addr_phase_t held;       // Last accepted phase
  ahb_input_pkg::ahb_addr_phase_t exp_phase;
  ahb_input_pkg::htrans_t         raw_trans;  // Type seen by burst rules
  ahb_input_pkg::hresp_t          exp_resp;
  logic acc;       // Active beat accepted this cycle
  logic pend;      // Reference pending flag
  logic dphase;    // Data phase of an active beat
  logic ovr;       // Reference burst override
  logic wrap_end;  // Last window beat was accepted
  logic exp_ready;

  // Last beat of a WRAP4/8/16 window, beat index taken from the scaled address
  function automatic logic last_in_window(input ahb_input_pkg::haddr_t a,
                                          input ahb_input_pkg::hsize_t s,
                                          input ahb_input_pkg::hburst_t b);
    int unsigned beats;
    int unsigned idx;
    case (b)
      `BUR_WRAP4:  beats = 4;
      `BUR_WRAP8:  beats = 8;
      `BUR_WRAP16: beats = 16;
      default:     beats = 0;
    endcase
    idx = (s > 3'd3) ? a : (a >> s);  // Wide sizes keep the raw bits
    return (beats != 0) && (idx % beats == beats - 1);
  endfunction

  assign live = {HSELS, HADDRS, HTRANSS, HWRITES, HSIZES, HBURSTS, HPROTS};  // Field order
  assign acc  = HSELS & HTRANSS[1] & HREADYS;
  assign raw_trans = pend ? held.trans : HTRANSS;

  // ----------------------------------------------------------------------
  // Reference state and reach counters
  // ----------------------------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      held        <= '0;
      pend        <= 1'b0;
      dphase      <= 1'b0;
      ovr         <= 1'b0;
      wrap_end    <= 1'b0;
      n_pass      <= 0;
      n_hold      <= 0;
      n_stall     <= 0;
      n_ovr       <= 0;
      n_wrap_seq  <= 0;
      n_wrap_busy <= 0;
    end
    else
    begin
      if (acc)
        held <= live;
      if (acc && !active_ip)
        pend <= 1'b1;                       // Output stage busy elsewhere
      else if (active_ip && readyout_ip)
        pend <= 1'b0;
      if (HREADYS)
        dphase <= HSELS & HTRANSS[1];
      if (HREADYS && (HTRANSS == `TRN_NONSEQ || HTRANSS == `TRN_IDLE))
        ovr <= 1'b0;
      else if (HREADYS && HTRANSS == `TRN_SEQ && acc && !active_ip)
        ovr <= 1'b1;                        // Burst cut downstream
      if (HTRANSS[1] && HREADYS)
        wrap_end <= last_in_window(HADDRS, HSIZES, HBURSTS);
      n_pass      <= n_pass + (!pend && acc);
      n_hold      <= n_hold + pend;
      n_stall     <= n_stall + (pend && active_ip && !readyout_ip);
      n_ovr       <= n_ovr + (ovr && !pend && HTRANSS == `TRN_SEQ);
      n_wrap_seq  <= n_wrap_seq + (ovr && wrap_end && !pend && HTRANSS == `TRN_SEQ);
      n_wrap_busy <= n_wrap_busy + (ovr && wrap_end && !pend && HTRANSS == `TRN_BUSY);
    end
  end

  // Expected outgoing phase
  always_comb
  begin
    exp_phase = live;
    if (pend)
    begin
      exp_phase       = held;
      exp_phase.sel   = 1'b1;
      exp_phase.trans = `TRN_NONSEQ;
    end
    if (ovr && raw_trans != `TRN_NONSEQ)
      exp_phase.burst = `BUR_INCR;
    if (ovr && wrap_end)
      exp_phase.trans[0] = 1'b0;  // SEQ to NONSEQ, BUSY to IDLE
  end

  // Expected response
  always_comb
  begin
    exp_ready = dphase ? (pend ? 1'b0 : readyout_ip) : 1'b1;
    exp_resp  = (dphase && !pend) ? resp_ip : `RSP_OKAY;
  end

  // ----------------------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------------------
  a_phase: assert property (@(posedge HCLK) disable iff (!HRESETn) ip_phase == exp_phase)
    else begin fail_count++; $error("error ip_phase %h expected %h",
                                    $sampled(ip_phase), $sampled(exp_phase)); end

  a_held: assert property (@(posedge HCLK) disable iff (!HRESETn)
                           held_tran_ip == (pend || acc))
    else begin fail_count++; $error("error held_tran_ip %h expected %h",
                                    $sampled(held_tran_ip), $sampled(pend || acc)); end

  a_ready: assert property (@(posedge HCLK) disable iff (!HRESETn) HREADYOUTS == exp_ready)
    else begin fail_count++; $error("error HREADYOUTS %h expected %h",
                                    $sampled(HREADYOUTS), $sampled(exp_ready)); end

  a_resp: assert property (@(posedge HCLK) disable iff (!HRESETn) HRESPS == exp_resp)
    else begin fail_count++; $error("error HRESPS %h expected %h",
                                    $sampled(HRESPS), $sampled(exp_resp)); end

  // First cycle out of reset
  a_reset: assert property (@(posedge HCLK) $rose(HRESETn) |->
                            HREADYOUTS && HRESPS == `RSP_OKAY && !held_tran_ip)
    else begin fail_count++; $error("error reset state HREADYOUTS %h HRESPS %h held_tran_ip %h",
                                    $sampled(HREADYOUTS), $sampled(HRESPS),
                                    $sampled(held_tran_ip)); end

endmodule

// ==== sim/tb_ahb_input_stage.sv ====
/*
  Testbench for the AHB input stage
  Clock, reset, manager sequences, watchdog and final report
*/
`timescale 1ns/10ps
`include "ahb_input_macros.svh"

module tb_ahb_input_stage;

  localparam real HALF_PERIOD = 2.0;  // 4 ns clock
  localparam int  NUM_SEQ     = 5;
  localparam int  SEQ_CYCLES  = 40;   // Budget per sequence

  logic                           HCLK;
  logic                           HRESETn;
  logic                           HSELS;
  ahb_input_pkg::haddr_t          HADDRS;
  ahb_input_pkg::htrans_t         HTRANSS;
  logic                           HWRITES;
  ahb_input_pkg::hsize_t          HSIZES;
  ahb_input_pkg::hburst_t         HBURSTS;
  ahb_input_pkg::hprot_t          HPROTS;
  logic                           HREADYS;
  logic                           active_ip;
  logic                           readyout_ip;
  ahb_input_pkg::hresp_t          resp_ip;
  logic                           HREADYOUTS;
  ahb_input_pkg::hresp_t          HRESPS;
  ahb_input_pkg::ahb_addr_phase_t ip_phase;
  logic                           held_tran_ip;

  int seed;
  int errors;      // Beats never accepted
  int misses;      // Cases never reached
  int stall_left;  // Cycles left with active_ip low
  int wait_left;   // Cycles left with readyout_ip low

  ahb_input_stage dut (.*);

  bind ahb_input_stage ahb_input_props u_props (.*);

  always #(HALF_PERIOD) HCLK = ~HCLK;

  function automatic ahb_input_pkg::haddr_t rand_word();
    return $random(seed) & 32'hFFFF_FFFC;  // Word aligned
  endfunction

  // ----------------------------------------------------------------------
  // Manager and output-stage drive
  // ----------------------------------------------------------------------
  task automatic drive_cycle(input logic sel, input ahb_input_pkg::haddr_t addr,
                             input ahb_input_pkg::htrans_t trans,
                             input ahb_input_pkg::hburst_t burst,
                             input logic write, input ahb_input_pkg::hprot_t prot);
    @(posedge HCLK);
    #0.5;
    HSELS   = sel;
    HADDRS  = addr;
    HTRANSS = trans;
    HBURSTS = burst;
    HWRITES = write;
    HPROTS  = prot;
    HSIZES  = 3'b010;  // Word beats throughout
    active_ip   = (stall_left == 0);
    readyout_ip = (stall_left > 0) || (wait_left == 0);
    if (stall_left > 0)
      stall_left--;
    else if (wait_left > 0)
      wait_left--;
    resp_ip = ($random(seed) & 1) ? `RSP_ERROR : `RSP_OKAY;
    #0.5;
    HREADYS = HREADYOUTS;  // Single-slave bus, ready comes back from this port
  endtask

  // One address phase, held until the bus is ready
  task automatic beat(input logic sel, input ahb_input_pkg::haddr_t addr,
                      input ahb_input_pkg::htrans_t trans,
                      input ahb_input_pkg::hburst_t burst);
    logic                  write;
    ahb_input_pkg::hprot_t prot;
    int                    guard;
    write = $random(seed);
    prot  = $random(seed);
    guard = 0;
    drive_cycle(sel, addr, trans, burst, write, prot);
    while (!HREADYS && guard < 30)
    begin
      drive_cycle(sel, addr, trans, burst, write, prot);
      guard++;
    end
    if (!HREADYS)
    begin
      $display("HREADYOUTS stuck low, beat at address %h never accepted", addr);
      errors++;
    end
  endtask

  task automatic idle_beat();
    beat(1'b0, '0, `TRN_IDLE, `BUR_SINGLE);
  endtask

  task automatic check_reached(input int count, input string what);
    if (count == 0)
    begin
      $display("%s was never reached", what);
      misses++;
    end
  endtask

  // ----------------------------------------------------------------------
  // Sequences
  // ----------------------------------------------------------------------
  task automatic pass_through_singles();
    for (int i = 0; i < 4; i++)
      beat(1'b1, rand_word(), `TRN_NONSEQ, `BUR_SINGLE);
    beat(1'b0, rand_word(), `TRN_NONSEQ, `BUR_SINGLE);  // Not selected
    wait_left = 2;                                       // Slave wait states
    beat(1'b1, rand_word(), `TRN_NONSEQ, `BUR_SINGLE);
    beat(1'b1, rand_word(), `TRN_NONSEQ, `BUR_SINGLE);
    idle_beat();
  endtask

  task automatic held_singles();
    stall_left = 3;
    beat(1'b1, rand_word(), `TRN_NONSEQ, `BUR_SINGLE);
    idle_beat();
    stall_left = 2;
    beat(1'b1, rand_word(), `TRN_NONSEQ, `BUR_SINGLE);
    beat(1'b1, rand_word(), `TRN_NONSEQ, `BUR_SINGLE);  // Waits behind the held one
    idle_beat();
  endtask

  task automatic stalled_replay();
    stall_left = 2;
    wait_left  = 3;  // Output stage slow to take the replay
    beat(1'b1, rand_word(), `TRN_NONSEQ, `BUR_SINGLE);
    beat(1'b1, rand_word(), `TRN_NONSEQ, `BUR_SINGLE);
    idle_beat();
  endtask

  task automatic cut_incr4_burst();
    ahb_input_pkg::haddr_t a;
    a = rand_word();
    beat(1'b1, a, `TRN_NONSEQ, `BUR_INCR4);
    stall_left = 2;  // Second beat lands while another port owns the output
    beat(1'b1, a + 4, `TRN_SEQ, `BUR_INCR4);
    beat(1'b1, a + 8, `TRN_SEQ, `BUR_INCR4);
    beat(1'b1, a + 12, `TRN_SEQ, `BUR_INCR4);
    beat(1'b1, rand_word(), `TRN_NONSEQ, `BUR_SINGLE);  // New transfer ends the override
    idle_beat();
  endtask

  task automatic cut_wrap4_burst();
    ahb_input_pkg::haddr_t base;
    base = rand_word() & 32'hFFFF_FFF0;  // 16 byte window
    beat(1'b1, base + 8, `TRN_NONSEQ, `BUR_WRAP4);
    stall_left = 2;
    beat(1'b1, base + 12, `TRN_SEQ, `BUR_WRAP4);  // Last beat of the window
    beat(1'b1, base, `TRN_BUSY, `BUR_WRAP4);
    beat(1'b1, base, `TRN_SEQ, `BUR_WRAP4);       // Wraps back to the start
    beat(1'b1, base + 4, `TRN_SEQ, `BUR_WRAP4);
    idle_beat();
  endtask

  // ----------------------------------------------------------------------
  // Main flow
  // ----------------------------------------------------------------------
  initial
  begin
    seed        = 21592;
    errors      = 0;
    misses      = 0;
    stall_left  = 0;
    wait_left   = 0;
    HCLK        = 1'b0;
    HRESETn     = 1'b0;
    HSELS       = 1'b0;
    HADDRS      = '0;
    HTRANSS     = `TRN_IDLE;
    HWRITES     = 1'b0;
    HSIZES      = 3'b010;
    HBURSTS     = `BUR_SINGLE;
    HPROTS      = '0;
    HREADYS     = 1'b1;
    active_ip   = 1'b1;
    readyout_ip = 1'b1;
    resp_ip     = `RSP_OKAY;
    repeat (3) @(posedge HCLK);
    #0.5;
    HRESETn = 1'b1;

    pass_through_singles();
    held_singles();
    stalled_replay();
    cut_incr4_burst();
    cut_wrap4_burst();
    idle_beat();

    check_reached(dut.u_props.n_pass, "pass-through beat");
    check_reached(dut.u_props.n_hold, "held transfer");
    check_reached(dut.u_props.n_stall, "stalled replay");
    check_reached(dut.u_props.n_ovr, "burst override on a SEQ beat");
    check_reached(dut.u_props.n_wrap_seq, "SEQ to NONSEQ at a wrap boundary");
    check_reached(dut.u_props.n_wrap_busy, "BUSY to IDLE at a wrap boundary");
    $display("assertion failures %0d, unreached cases %0d, stuck beats %0d",
             dut.u_props.fail_count, misses, errors);
    if (dut.u_props.fail_count == 0 && misses == 0 && errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(NUM_SEQ * SEQ_CYCLES * 2 * HALF_PERIOD);
    $display("watchdog expired, sequences did not finish in %0d cycles",
             NUM_SEQ * SEQ_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
